// ==== common/imuldiv_op_pkg.sv ====
//--------------------------------------------------------------------------
// request opcodes for the iterative multiply/divide unit
//--------------------------------------------------------------------------
`default_nettype none

package imuldiv_op_pkg;

  //------------------------------------------------------------------------
  // request function
  //------------------------------------------------------------------------

  // two bits wide, one encoding left unused
  // fn_mul returns the full signed product in 2*xlen bits
  // fn_div and fn_divu return {remainder, quotient}
  typedef enum logic [1:0] {
    // signed multiply
    FN_MUL  = 2'd0,
    // signed divide, remainder takes the dividend sign
    FN_DIV  = 2'd1,
    // unsigned divide
    FN_DIVU = 2'd2
  } muldiv_fn_e;

  // 2'd3 is not decoded by the top, a request carrying it starts no unit

endpackage

`default_nettype wire

// ==== common/imuldiv_state_pkg.sv ====
//--------------------------------------------------------------------------
// control states shared by the iterative multiplier and divider
//--------------------------------------------------------------------------
`default_nettype none

package imuldiv_state_pkg;

  // idle -> calc -> done -> idle, one operation at a time
  typedef enum logic [1:0] {
    // waiting for req_val
    ST_IDLE = 2'd0,
    // one iteration per cycle until the counter hits zero
    ST_CALC = 2'd1,
    // sign fix, then hold the response until resp_rdy
    ST_DONE = 2'd2
  } iter_state_e;

endpackage

`default_nettype wire

// ==== div/int_div_iterative.sv ====
//--------------------------------------------------------------------------
// iterative restoring divider, signed or unsigned per request
// control fsm, iteration counter and remainder/quotient sign fix
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_div_iterative
  import imuldiv_state_pkg::*;
#(
  parameter int xlen = 32
) (
  input  wire                 clk,
  input  wire                 reset,

  input  wire  [xlen-1:0]     req_a,
  input  wire  [xlen-1:0]     req_b,
  input  wire                 req_signed,
  input  wire                 req_val,

  output logic [2*xlen-1:0]   resp_result,
  output logic                resp_val,
  input  wire                 resp_rdy
);

  localparam int cnt_w = $clog2(xlen);

  iter_state_e         state;
  logic [cnt_w-1:0]    cnt;

  // partial remainder, always below the divisor between steps
  logic [xlen-1:0]     rem;
  // dividend bits leave at the top, quotient bits enter at the bottom
  logic [xlen-1:0]     quo;
  logic [xlen-1:0]     divisor;
  logic                q_sign;
  logic                r_sign;

  logic [xlen-1:0]     a_mag;
  logic [xlen-1:0]     b_mag;
  // one spare bit for the shifted remainder, one more for the borrow
  logic [xlen:0]       shifted;
  logic [xlen+1:0]     diff;
  logic                diff_neg;
  logic                cnt_zero;
  logic                start;
  logic                fire_resp;

  //------------------------------------------------------------------------
  // operand conditioning and one restoring step
  //------------------------------------------------------------------------

  // raw operands for unsigned requests
  assign a_mag = (req_signed && req_a[xlen-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (req_signed && req_b[xlen-1]) ? (~req_b + 1'b1) : req_b;

  assign shifted  = {rem, quo[xlen-1]};
  assign diff     = {1'b0, shifted} - {2'b00, divisor};
  assign diff_neg = diff[xlen+1];

  assign cnt_zero  = (cnt == '0);
  assign start     = (state == ST_IDLE) && req_val;
  assign fire_resp = resp_val && resp_rdy;

  //------------------------------------------------------------------------
  // control
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_val) begin
            state <= ST_CALC;
          end
        end
        ST_CALC: begin
          if (cnt_zero) begin
            state <= ST_DONE;
          end
        end
        // back-pressure simply parks the unit here
        ST_DONE: begin
          if (fire_resp) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (start) begin
      cnt <= cnt_w'(xlen - 1);
    end else if (state == ST_CALC && !cnt_zero) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (state == ST_DONE && !resp_val) begin
      resp_val <= 1'b1;
    end else if (fire_resp) begin
      resp_val <= 1'b0;
    end
  end

  //------------------------------------------------------------------------
  // datapath
  //------------------------------------------------------------------------

  // a zero divisor never borrows, so every quotient bit is set and the
  // dividend ends up whole in the remainder
  always_ff @(posedge clk) begin
    if (start) begin
      rem     <= '0;
      quo     <= a_mag;
      divisor <= b_mag;
      q_sign  <= req_signed && (req_a[xlen-1] ^ req_b[xlen-1]);
      r_sign  <= req_signed && req_a[xlen-1];
    end else if (state == ST_CALC) begin
      if (diff_neg) begin
        // restore, keep the shifted value
        rem <= shifted[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b0};
      end else begin
        rem <= diff[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b1};
      end
    end else if (state == ST_DONE && !resp_val) begin
      // quotient sign from both operands, remainder follows the dividend
      if (q_sign) begin
        quo <= ~quo + 1'b1;
      end
      if (r_sign) begin
        rem <= ~rem + 1'b1;
      end
    end
  end

  // remainder in the upper half, quotient in the lower half
  assign resp_result = {rem, quo};

  // the top only offers a request while this unit sits in idle
  a_req_idle: assert property (@(posedge clk) disable iff (reset)
    req_val |-> state == ST_IDLE);

endmodule

`default_nettype wire

// ==== hdl/imuldiv_iterative.sv ====
//--------------------------------------------------------------------------
// iterative multiply/divide top, steers requests to the two units,
// tracks the single outstanding operation and selects its response
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module imuldiv_iterative
  import imuldiv_op_pkg::*;
#(
  parameter int xlen = 32
) (
  input  wire                 clk,
  input  wire                 reset,

  input  var muldiv_fn_e      req_fn,
  input  wire  [xlen-1:0]     req_a,
  input  wire  [xlen-1:0]     req_b,
  input  wire                 req_val,
  output logic                req_rdy,

  output logic [2*xlen-1:0]   resp_result,
  output logic                resp_val,
  input  wire                 resp_rdy
);

  // one operation in flight from acceptance to response transfer
  logic                busy;
  // opcode of the operation in flight
  muldiv_fn_e          cur_fn;

  logic                is_mul;
  logic                is_div;
  logic                cur_is_mul;
  logic                mul_req_val;
  logic                div_req_val;
  logic                accept;

  logic [2*xlen-1:0]   mul_result;
  logic [2*xlen-1:0]   div_result;
  logic                mul_resp_val;
  logic                div_resp_val;

  //------------------------------------------------------------------------
  // request steering
  //------------------------------------------------------------------------

  assign is_mul  = (req_fn == FN_MUL);
  assign is_div  = (req_fn == FN_DIV) || (req_fn == FN_DIVU);
  assign req_rdy = !busy;

  assign mul_req_val = req_val && !busy && is_mul;
  assign div_req_val = req_val && !busy && is_div;
  // an undecoded opcode starts no unit and leaves busy clear
  assign accept      = mul_req_val || div_req_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      cur_fn <= FN_MUL;
    end else if (accept) begin
      busy   <= 1'b1;
      cur_fn <= req_fn;
    end else if (resp_val && resp_rdy) begin
      busy   <= 1'b0;
    end
  end

  //------------------------------------------------------------------------
  // units and response select
  //------------------------------------------------------------------------

  int_mul_iterative #(.xlen(xlen)) mul_unit (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .resp_result (mul_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (resp_rdy && cur_is_mul)
  );

  int_div_iterative #(.xlen(xlen)) div_unit (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (req_fn == FN_DIV),
    .req_val     (div_req_val),
    .resp_result (div_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (resp_rdy && !cur_is_mul)
  );

  assign cur_is_mul  = (cur_fn == FN_MUL);
  assign resp_val    = cur_is_mul ? mul_resp_val : div_resp_val;
  assign resp_result = cur_is_mul ? mul_result : div_result;

  // a response only appears for an operation this top accepted
  a_resp_busy: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> busy);

endmodule

`default_nettype wire

// ==== mul/int_mul_iterative.sv ====
//--------------------------------------------------------------------------
// iterative signed multiplier, shift-and-add on operand magnitudes
// control fsm, iteration counter and final sign fix in one module
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative
  import imuldiv_state_pkg::*;
#(
  parameter int xlen = 32
) (
  input  wire                 clk,
  input  wire                 reset,

  input  wire  [xlen-1:0]     req_a,
  input  wire  [xlen-1:0]     req_b,
  input  wire                 req_val,

  output logic [2*xlen-1:0]   resp_result,
  output logic                resp_val,
  input  wire                 resp_rdy
);

  // counter holds xlen-1 down to 0
  localparam int cnt_w = $clog2(xlen);

  iter_state_e         state;
  logic [cnt_w-1:0]    cnt;

  // multiplicand shifts left into the upper half
  logic [2*xlen-1:0]   mcand;
  // multiplier shifts right, low bit picks the add
  logic [xlen-1:0]     mplier;
  logic [2*xlen-1:0]   acc;
  // product is negative when exactly one operand is
  logic                sign;

  logic [xlen-1:0]     a_mag;
  logic [xlen-1:0]     b_mag;
  logic                cnt_zero;
  logic                start;
  logic                fire_resp;

  //------------------------------------------------------------------------
  // operand conditioning and handshake terms
  //------------------------------------------------------------------------

  // two's complement negate of negative operands
  // most negative value maps onto its own pattern, read as unsigned
  assign a_mag     = req_a[xlen-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag     = req_b[xlen-1] ? (~req_b + 1'b1) : req_b;

  assign cnt_zero  = (cnt == '0);
  assign start     = (state == ST_IDLE) && req_val;
  assign fire_resp = resp_val && resp_rdy;

  //------------------------------------------------------------------------
  // control
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_val) begin
            state <= ST_CALC;
          end
        end
        // last iteration runs on the cycle the counter reads zero
        ST_CALC: begin
          if (cnt_zero) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (fire_resp) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (start) begin
      cnt <= cnt_w'(xlen - 1);
    end else if (state == ST_CALC && !cnt_zero) begin
      cnt <= cnt - 1'b1;
    end
  end

  // first done cycle applies the sign, valid follows on the next edge
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (state == ST_DONE && !resp_val) begin
      resp_val <= 1'b1;
    end else if (fire_resp) begin
      resp_val <= 1'b0;
    end
  end

  //------------------------------------------------------------------------
  // datapath
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (start) begin
      mcand  <= {{xlen{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      sign   <= req_a[xlen-1] ^ req_b[xlen-1];
    end else if (state == ST_CALC) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (state == ST_DONE && !resp_val && sign) begin
      acc <= ~acc + 1'b1;
    end
  end

  // accumulator already carries the sign once resp_val is up
  assign resp_result = acc;

  // the top only offers a request while this unit sits in idle
  a_req_idle: assert property (@(posedge clk) disable iff (reset)
    req_val |-> state == ST_IDLE);

  // calc counts down one step per cycle and leaves only from zero
  a_cnt_nowrap: assert property (@(posedge clk) disable iff (reset)
    state == ST_CALC |=> (state == ST_CALC && !$past(cnt_zero)
                          && cnt == $past(cnt) - 1'b1)
                      || (state == ST_DONE && $past(cnt_zero)));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the imuldiv testbench with verilator, run it, and grep the log

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_imuldiv
log_file=sim.log

verilator --binary --assert -f tb.f --top-module tb_imuldiv \
  -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Done: no errors" "$log_file"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== tb.f ====
+incdir+testbench
common/imuldiv_op_pkg.sv
common/imuldiv_state_pkg.sv
mul/int_mul_iterative.sv
div/int_div_iterative.sv
hdl/imuldiv_iterative.sv
testbench/tb_imuldiv.sv

// ==== testbench/imuldiv_checks.svh ====
//--------------------------------------------------------------------------
// reference product and quotient/remainder, typed compare tasks for
// results, opcodes, latency and handshake flags
//--------------------------------------------------------------------------
`ifndef IMULDIV_CHECKS_SVH
`define IMULDIV_CHECKS_SVH

// included inside tb_imuldiv, uses its xlen, checks and errors

// full signed product in 2*xlen bits
function automatic logic [2*xlen-1:0] ref_product(input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
  longint sa;
  longint sb;
  sa = longint'($signed(a));
  sb = longint'($signed(b));
  return sa * sb;
endfunction

// {remainder, quotient}, truncating division, remainder keeps the dividend sign
// zero divisor gives all ones, negated when a signed dividend is negative
function automatic logic [2*xlen-1:0] ref_divide(input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b,
                                                 input logic is_signed);
  logic [xlen-1:0] q;
  logic [xlen-1:0] r;
  longint sa;
  longint sb;
  sa = longint'($signed(a));
  sb = longint'($signed(b));
  if (b == '0) begin
    r = a;
    q = '1;
    if (is_signed && a[xlen-1]) begin
      q = {{(xlen-1){1'b0}}, 1'b1};
    end
  end else if (is_signed) begin
    // longint holds most negative / -1 without overflow
    q = xlen'(sa / sb);
    r = xlen'(sa % sb);
  end else begin
    q = a / b;
    r = a % b;
  end
  return {r, q};
endfunction

function automatic logic [2*xlen-1:0] expected_result(input muldiv_fn_e fn,
                                                      input logic [xlen-1:0] a,
                                                      input logic [xlen-1:0] b);
  case (fn)
    FN_MUL:  return ref_product(a, b);
    FN_DIV:  return ref_divide(a, b, 1'b1);
    default: return ref_divide(a, b, 1'b0);
  endcase
endfunction

task automatic check_result(input string name, input logic [2*xlen-1:0] got,
                            input logic [2*xlen-1:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error: time %0t, %s got %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_fn(input string name, input muldiv_fn_e got, input muldiv_fn_e exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error: time %0t, %s got %s, expected %s", $time, name, got.name(),
             exp.name());
  end
endtask

task automatic check_latency(input string name, input int got, input int exp);
  checks++;
  if (got != exp) begin
    errors++;
    $display("Error: time %0t, %s got %0d, expected %0d", $time, name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error: time %0t, %s got %b, expected %b", $time, name, got, exp);
  end
endtask

`endif

// ==== testbench/tb_imuldiv.sv ====
//--------------------------------------------------------------------------
// testbench for the iterative multiply/divide top: directed, random and
// back-pressure requests, in-order response compare, latency, timeout
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_imuldiv
  import imuldiv_op_pkg::*;
();

  localparam int xlen = 32;
  localparam int n_mul = 9;
  localparam int n_div = 13;
  localparam int n_rand = 200;
  localparam int n_bp = 30;
  // every request gets xlen+10 cycles, plus slack for reset and drains
  localparam int cycle_limit = (n_mul + n_div + n_rand + n_bp) * (xlen + 10) + 1000;

  // one accepted request, kept until its response transfers
  typedef struct packed {
    muldiv_fn_e      fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    int              acc_cyc;
  } req_rec_t;

  logic               clk;
  logic               reset;
  muldiv_fn_e         req_fn;
  logic [xlen-1:0]    req_a;
  logic [xlen-1:0]    req_b;
  logic               req_val;
  logic               req_rdy;
  logic [2*xlen-1:0]  resp_result;
  logic               resp_val;
  logic               resp_rdy;

  int checks = 0;
  int errors = 0;
  int sent_count = 0;
  int resp_count = 0;
  int resp_base = 0;
  int err_base = 0;
  int timeout_cycles;
  logic bp_on = 1'b0;
  int stretch = 0;

  // compare process state
  req_rec_t pending[$];
  req_rec_t rec;
  int mon_cycle = 0;
  logic in_flight = 1'b0;
  logic rise_seen = 1'b0;
  logic hold_pending = 1'b0;
  logic [2*xlen-1:0] hold_result;

`include "imuldiv_checks.svh"

  imuldiv_iterative #(.xlen(xlen)) uut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //------------------------------------------------------------------------
  // driver helpers, all called 1 ns after a rising edge
  //------------------------------------------------------------------------

  // holds the request until an edge sees req_rdy high
  task automatic send_req(input muldiv_fn_e fn, input logic [xlen-1:0] a,
                          input logic [xlen-1:0] b);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    while (!req_rdy) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
    sent_count++;
  endtask

  // drains outstanding responses, then one line for the test
  task automatic report_test(input string name);
    while (resp_count != sent_count) begin
      @(posedge clk);
      #1;
    end
    $display("test %s: %0d responses, %0d errors", name, resp_count - resp_base,
             errors - err_base);
    resp_base = resp_count;
    err_base  = errors;
  endtask

  function automatic muldiv_fn_e pick_fn();
    case ($urandom_range(0, 2))
      0:       return FN_MUL;
      1:       return FN_DIV;
      default: return FN_DIVU;
    endcase
  endfunction

  // mix of zero, small, small negative, most negative and full range
  function automatic logic [xlen-1:0] pick_operand();
    case ($urandom_range(0, 5))
      0:       return '0;
      1:       return $urandom_range(1, 15);
      2:       return ~$urandom_range(0, 15);
      3:       return 32'h8000_0000;
      default: return $urandom;
    endcase
  endfunction

  //------------------------------------------------------------------------
  // response ready, random low stretches while back-pressure is on
  //------------------------------------------------------------------------

  initial begin
    resp_rdy = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!bp_on) begin
        resp_rdy = 1'b1;
      end else if (stretch > 0) begin
        resp_rdy = 1'b0;
        stretch--;
      end else if (resp_rdy && $urandom_range(0, 2) == 0) begin
        resp_rdy = 1'b0;
        stretch  = $urandom_range(1, 8) - 1;
      end else begin
        resp_rdy = 1'b1;
      end
    end
  end

  //------------------------------------------------------------------------
  // compare process, samples the values that stood before each edge
  //------------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      in_flight    = 1'b0;
      rise_seen    = 1'b0;
      hold_pending = 1'b0;
    end else begin
      mon_cycle++;
      // a stalled response must not move
      if (hold_pending) begin
        check_flag("resp_val", resp_val, 1'b1);
        check_result("resp_result", resp_result, hold_result);
      end
      hold_pending = resp_val && !resp_rdy;
      hold_result  = resp_result;
      if (in_flight) begin
        check_flag("req_rdy", req_rdy, 1'b0);
      end
      // resp_val rose on the previous edge
      if (resp_val && !rise_seen) begin
        rise_seen = 1'b1;
        if (pending.size() == 0) begin
          errors++;
          $display("response valid at time %0t with no request outstanding", $time);
        end else begin
          check_latency("latency", mon_cycle - 1 - pending[0].acc_cyc, xlen + 1);
        end
      end
      if (resp_val && resp_rdy && pending.size() != 0) begin
        rec = pending.pop_front();
        // opcode the top recorded for the operation in flight
        check_fn("cur_fn", uut.cur_fn, rec.fn);
        check_result("resp_result", resp_result, expected_result(rec.fn, rec.a, rec.b));
        resp_count++;
        rise_seen = 1'b0;
        in_flight = 1'b0;
      end
      if (req_val && req_rdy) begin
        if (in_flight) begin
          errors++;
          $display("request accepted at time %0t while one is outstanding", $time);
        end
        rec.fn      = req_fn;
        rec.a       = req_a;
        rec.b       = req_b;
        rec.acc_cyc = mon_cycle;
        pending.push_back(rec);
        in_flight = 1'b1;
      end
    end
  end

  //------------------------------------------------------------------------
  // timeout
  //------------------------------------------------------------------------

  initial begin
    timeout_cycles = 0;
    while (timeout_cycles < cycle_limit) begin
      @(posedge clk);
      timeout_cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Done: errors found");
    $finish;
  end

  //------------------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h9968));
    reset   = 1'b1;
    req_val = 1'b0;
    req_fn  = FN_MUL;
    req_a   = '0;
    req_b   = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    check_flag("resp_val", resp_val, 1'b0);
    check_flag("req_rdy", req_rdy, 1'b1);
    report_test("reset");

    // signs, zero and the most negative corner cases
    send_req(FN_MUL, 32'd3, 32'd5);
    send_req(FN_MUL, 32'hFFFF_FFF9, 32'd6);
    send_req(FN_MUL, 32'd0, 32'h1234_5678);
    send_req(FN_MUL, 32'h7FFF_FFFF, 32'h7FFF_FFFF);
    send_req(FN_MUL, 32'h8000_0000, 32'h8000_0000);
    send_req(FN_MUL, 32'h8000_0000, 32'hFFFF_FFFF);
    send_req(FN_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    send_req(FN_MUL, 32'h1234_5678, 32'hFEDC_BA98);
    send_req(FN_MUL, 32'h8000_0000, 32'h7FFF_FFFF);
    report_test("directed_mul");

    // -100 is 32'hFFFF_FF9C, -7 is 32'hFFFF_FFF9
    send_req(FN_DIV,  32'd100, 32'd7);
    send_req(FN_DIVU, 32'd100, 32'd7);
    send_req(FN_DIV,  32'hFFFF_FF9C, 32'd7);
    send_req(FN_DIV,  32'd100, 32'hFFFF_FFF9);
    send_req(FN_DIV,  32'hFFFF_FF9C, 32'hFFFF_FFF9);
    send_req(FN_DIVU, 32'hFFFF_FF9C, 32'd7);
    send_req(FN_DIV,  32'h0000_1234, 32'd0);
    send_req(FN_DIV,  32'hFFFF_FF9C, 32'd0);
    send_req(FN_DIVU, 32'hFFFF_FF9C, 32'd0);
    send_req(FN_DIV,  32'h8000_0000, 32'hFFFF_FFFF);
    send_req(FN_DIVU, 32'hFFFF_FFFF, 32'd1);
    send_req(FN_DIV,  32'd5, 32'd10);
    send_req(FN_DIVU, 32'd0, 32'd3);
    report_test("directed_div");

    repeat (n_rand) begin
      send_req(pick_fn(), pick_operand(), pick_operand());
    end
    report_test("random");

    bp_on = 1'b1;
    repeat (n_bp) begin
      send_req(pick_fn(), pick_operand(), pick_operand());
    end
    report_test("backpressure");
    bp_on = 1'b0;

    $display("checks: %0d, responses: %0d, errors: %0d", checks, resp_count, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
